// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = chip_feeder_tb
FILELIST = chip_feeder.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// File: chip_feeder.f
logic/feeder_pkg.sv
logic/xfer_if.sv
logic/fetch_if.sv
logic/burst_sequencer.sv
logic/addr_gen.sv
logic/block_rom.sv
logic/bus_driver.sv
logic/chip_feeder.sv
test/chip_feeder_tb.sv

// File: logic/addr_gen.sv
`default_nettype none
`timescale 1ns/1ps

module addr_gen (
    input  wire  clk,
    input  wire  rst_n,
    xfer_if.addr xfer,
    fetch_if.src fetch
);
    import feeder_pkg::*;

    logic [addr_w-1:0] base_q [num_codes];  // current base per code
    logic [addr_w-1:0] addr_q;
    logic              beat_q;
    logic              last_q;

    logic [len_w-1:0]  len;
    logic [len_w-1:0]  offset;      // current base minus region start
    logic [len_w-1:0]  offset_nxt;
    logic [len_w-1:0]  region;      // words in this code's region
    logic [addr_w-1:0] base_nxt;

    // ============================================================
    // circular base table
    // ============================================================
    assign len        = burst_len_tab[xfer.code];
    assign offset     = len_w'(base_q[xfer.code]) - len_w'(base_tab[xfer.code]);
    assign offset_nxt = offset + len;
    assign region     = len * len_w'(num_blk_tab[xfer.code]);

    always_comb begin
        if (offset_nxt >= region) begin
            base_nxt = base_tab[xfer.code];  // wrap to region start
        end else begin
            base_nxt = base_q[xfer.code] + addr_w'(len);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_codes; i++) begin
                base_q[i] <= base_tab[i];
            end
        end else if (xfer.done && xfer.rd_mode) begin
            base_q[xfer.code] <= base_nxt;  // write mode leaves base alone
        end
    end

    // ============================================================
    // running read address and beat markers
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (xfer.start) begin
            addr_q <= base_q[xfer.code];
        end else if (xfer.fetch) begin
            addr_q <= addr_q + 6'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= 1'b0;
            last_q <= 1'b0;
        end else begin
            beat_q <= xfer.fetch;  // rom answers one cycle later
            last_q <= xfer.done;
        end
    end

    assign fetch.en        = xfer.fetch;
    assign fetch.addr      = addr_q;
    assign fetch.beat      = beat_q;
    assign fetch.last_beat = last_q;

endmodule

`default_nettype wire

// File: logic/block_rom.sv
`default_nettype none
`timescale 1ns/1ps

module block_rom (
    input  wire                           clk,
    fetch_if.rom                          fetch,
    output logic [feeder_pkg::data_w-1:0] rdata
);
    import feeder_pkg::*;

    logic [data_w-1:0] mem [rom_depth];

    // contents come from the board image
    initial begin
        $readmemh("rom_init.hex", mem);
    end

    // registered read, one cycle
    always_ff @(posedge clk) begin
        if (fetch.en) begin
            rdata <= mem[fetch.addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/burst_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module burst_sequencer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  req,
    input  wire feeder_pkg::code_t code,
    input  wire                  rd_mode,
    xfer_if.seq                  xfer
);
    import feeder_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_config,
        st_wait,
        st_rd_data
    } state_t;

    state_t           state_q;
    state_t           state_nxt;
    code_t            code_q;
    logic             rd_mode_q;
    logic [len_w-1:0] cnt_q;      // beats issued in RD_DATA
    logic [len_w-1:0] burst_len;
    logic             last_cycle;

    assign burst_len  = burst_len_tab[code_q];
    assign last_cycle = (cnt_q == burst_len - 8'd1);

    // ============================================================
    // transfer FSM
    // ============================================================
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            st_idle:    if (req) state_nxt = st_config;  // busy req is dropped
            st_config:  state_nxt = st_wait;
            st_wait:    state_nxt = st_rd_data;
            st_rd_data: if (last_cycle) state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            code_q    <= code_cfg;
            rd_mode_q <= 1'b0;
        end else begin
            state_q <= state_nxt;
            if (state_q == st_idle && req) begin  // accept edge
                code_q    <= code;
                rd_mode_q <= rd_mode;
            end
        end
    end

    // beat counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (state_q == st_rd_data) begin
            cnt_q <= cnt_q + 8'd1;
        end else begin
            cnt_q <= '0;
        end
    end

    assign xfer.start   = (state_q == st_config);
    assign xfer.fetch   = (state_nxt == st_rd_data);  // address leads data by one
    assign xfer.done    = (state_q == st_rd_data) && last_cycle;
    assign xfer.code    = code_q;
    assign xfer.rd_mode = rd_mode_q;

endmodule

`default_nettype wire

// File: logic/bus_driver.sv
`default_nettype none
`timescale 1ns/1ps

module bus_driver (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire [feeder_pkg::data_w-1:0]  rdata,
    fetch_if.drv                          fetch,
    output logic [feeder_pkg::data_w-1:0] data,
    output logic                          oe_n,
    output logic                          cs_n
);

    // ============================================================
    // output registers toward the chip
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data <= '0;
        end else if (fetch.beat) begin
            data <= rdata;
        end else begin
            data <= '0;  // bus idles at zero
        end
    end

    // chip select follows the beats exactly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_n <= 1'b1;
        end else begin
            cs_n <= ~fetch.beat;
        end
    end

    // output enable stays low one extra cycle after the last beat,
    // giving the pad time to turn around
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            oe_n <= 1'b1;
        end else begin
            oe_n <= ~(fetch.beat | fetch.last_beat);
        end
    end

endmodule

`default_nettype wire

// File: logic/chip_feeder.sv
`default_nettype none
`timescale 1ns/1ps

module chip_feeder (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           req,
    input  wire [feeder_pkg::code_w-1:0]  code,
    input  wire                           rd_mode,
    output logic [feeder_pkg::data_w-1:0] data,
    output logic                          oe_n,
    output logic                          cs_n
);
    import feeder_pkg::*;

    logic [data_w-1:0] rdata;  // rom word toward the driver

    xfer_if  xfer_i ();
    fetch_if fetch_i ();

    // ============================================================
    // four-stage chain
    // ============================================================
    burst_sequencer seq_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .code    (code_t'(code)),  // unknown codes keep their raw value
        .rd_mode (rd_mode),
        .xfer    (xfer_i.seq)
    );

    addr_gen addr_i (
        .clk   (clk),
        .rst_n (rst_n),
        .xfer  (xfer_i.addr),
        .fetch (fetch_i.src)
    );

    block_rom rom_i (
        .clk   (clk),
        .fetch (fetch_i.rom),
        .rdata (rdata)
    );

    bus_driver drv_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rdata (rdata),
        .fetch (fetch_i.drv),
        .data  (data),
        .oe_n  (oe_n),
        .cs_n  (cs_n)
    );

endmodule

`default_nettype wire

// File: logic/feeder_pkg.sv
`default_nettype none

package feeder_pkg;

    // ============================================================
    // widths and sizes
    // ============================================================
    localparam int data_w    = 128;
    localparam int code_w    = 4;
    localparam int addr_w    = 6;
    localparam int len_w     = 8;
    localparam int blk_w     = 4;
    localparam int rom_depth = 64;
    localparam int num_codes = 2 ** code_w;

    // interface codes as sent by the chip
    typedef enum logic [code_w-1:0] {
        code_cfg      = 4'd0,
        code_flg_ofm  = 4'd1,
        code_ofm      = 4'd2,
        code_wei_addr = 4'd3,
        code_wei      = 4'd4,
        code_flg_wei  = 4'd5,
        code_act      = 4'd6,
        code_flg_act  = 4'd7
    } code_t;

    // ============================================================
    // per-code tables, indexed by the raw 4-bit code
    // ============================================================
    localparam logic [len_w-1:0] default_len = 8'd4;

    // beats per burst
    localparam logic [len_w-1:0] burst_len_tab [num_codes] = '{
        code_wei_addr : 8'd3,
        default       : default_len
    };

    // blocks per code, base wraps after this many bursts
    localparam logic [blk_w-1:0] num_blk_tab [num_codes] = '{
        code_wei_addr : 4'd2,
        code_flg_wei  : 4'd2,
        code_wei      : 4'd4,
        code_flg_act  : 4'd2,
        code_act      : 4'd3,
        default       : 4'd1  // cfg, ofm, flg_ofm and unknown codes
    };

    // region starts, each region is burst length x block count words
    localparam logic [addr_w-1:0] base_tab [num_codes] = '{
        code_cfg      : 6'd0,   // 4 x 1
        code_wei_addr : 6'd4,   // 3 x 2
        code_flg_wei  : 6'd10,  // 4 x 2
        code_wei      : 6'd18,  // 4 x 4
        code_flg_act  : 6'd34,  // 4 x 2
        code_act      : 6'd42,  // 4 x 3
        code_ofm      : 6'd54,  // 4 x 1
        code_flg_ofm  : 6'd58,  // 4 x 1, ends at 62
        default       : 6'd0
    };

endpackage

`default_nettype wire

// File: logic/fetch_if.sv
`default_nettype none
`timescale 1ns/1ps

interface fetch_if;
    import feeder_pkg::*;

    logic              en;         // rom read enable
    logic [addr_w-1:0] addr;
    logic              beat;       // rom data valid this cycle
    logic              last_beat;  // one cycle after done

    modport src (
        output en, addr, beat, last_beat
    );

    modport rom (
        input en, addr
    );

    modport drv (
        input beat, last_beat
    );

endinterface

`default_nettype wire

// File: logic/xfer_if.sv
`default_nettype none
`timescale 1ns/1ps

// burst control from the sequencer to the address stage
interface xfer_if;
    import feeder_pkg::*;

    logic  start;    // pulse in CONFIG
    code_t code;     // held from capture
    logic  fetch;    // high the cycle before each beat
    logic  done;     // pulse in last burst cycle
    logic  rd_mode;  // sampled at capture

    modport seq (
        output start, code, fetch, done, rd_mode
    );

    modport addr (
        input start, code, fetch, done, rd_mode
    );

endinterface

`default_nettype wire

// File: rom_init.hex
// 64 words from address 0 up
// each 32-bit lane holds lane id then address then inverted address then 5a
3300ff5a2200ff5a1100ff5a0000ff5a
3301fe5a2201fe5a1101fe5a0001fe5a
3302fd5a2202fd5a1102fd5a0002fd5a
3303fc5a2203fc5a1103fc5a0003fc5a
3304fb5a2204fb5a1104fb5a0004fb5a
3305fa5a2205fa5a1105fa5a0005fa5a
3306f95a2206f95a1106f95a0006f95a
3307f85a2207f85a1107f85a0007f85a
3308f75a2208f75a1108f75a0008f75a
3309f65a2209f65a1109f65a0009f65a
330af55a220af55a110af55a000af55a
330bf45a220bf45a110bf45a000bf45a
330cf35a220cf35a110cf35a000cf35a
330df25a220df25a110df25a000df25a
330ef15a220ef15a110ef15a000ef15a
330ff05a220ff05a110ff05a000ff05a
3310ef5a2210ef5a1110ef5a0010ef5a
3311ee5a2211ee5a1111ee5a0011ee5a
3312ed5a2212ed5a1112ed5a0012ed5a
3313ec5a2213ec5a1113ec5a0013ec5a
3314eb5a2214eb5a1114eb5a0014eb5a
3315ea5a2215ea5a1115ea5a0015ea5a
3316e95a2216e95a1116e95a0016e95a
3317e85a2217e85a1117e85a0017e85a
3318e75a2218e75a1118e75a0018e75a
3319e65a2219e65a1119e65a0019e65a
331ae55a221ae55a111ae55a001ae55a
331be45a221be45a111be45a001be45a
331ce35a221ce35a111ce35a001ce35a
331de25a221de25a111de25a001de25a
331ee15a221ee15a111ee15a001ee15a
331fe05a221fe05a111fe05a001fe05a
3320df5a2220df5a1120df5a0020df5a
3321de5a2221de5a1121de5a0021de5a
3322dd5a2222dd5a1122dd5a0022dd5a
3323dc5a2223dc5a1123dc5a0023dc5a
3324db5a2224db5a1124db5a0024db5a
3325da5a2225da5a1125da5a0025da5a
3326d95a2226d95a1126d95a0026d95a
3327d85a2227d85a1127d85a0027d85a
3328d75a2228d75a1128d75a0028d75a
3329d65a2229d65a1129d65a0029d65a
332ad55a222ad55a112ad55a002ad55a
332bd45a222bd45a112bd45a002bd45a
332cd35a222cd35a112cd35a002cd35a
332dd25a222dd25a112dd25a002dd25a
332ed15a222ed15a112ed15a002ed15a
332fd05a222fd05a112fd05a002fd05a
3330cf5a2230cf5a1130cf5a0030cf5a
3331ce5a2231ce5a1131ce5a0031ce5a
3332cd5a2232cd5a1132cd5a0032cd5a
3333cc5a2233cc5a1133cc5a0033cc5a
3334cb5a2234cb5a1134cb5a0034cb5a
3335ca5a2235ca5a1135ca5a0035ca5a
3336c95a2236c95a1136c95a0036c95a
3337c85a2237c85a1137c85a0037c85a
3338c75a2238c75a1138c75a0038c75a
3339c65a2239c65a1139c65a0039c65a
333ac55a223ac55a113ac55a003ac55a
333bc45a223bc45a113bc45a003bc45a
333cc35a223cc35a113cc35a003cc35a
333dc25a223dc25a113dc25a003dc25a
333ec15a223ec15a113ec15a003ec15a
333fc05a223fc05a113fc05a003fc05a

// File: test/chip_feeder_tb.sv
`default_nettype none
`timescale 1ns/1ps

module chip_feeder_tb;

    logic         clk;
    logic         rst_n;
    logic         req;
    logic [3:0]   code;
    logic         rd_mode;
    logic [127:0] data;
    logic         oe_n;
    logic         cs_n;

    logic [127:0] rom_model [64];  // own copy of the board image
    int           blk_model [16];  // next block to read, per code
    int           check_errors;
    int           timeout_errors;

    chip_feeder dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .code    (code),
        .rd_mode (rd_mode),
        .data    (data),
        .oe_n    (oe_n),
        .cs_n    (cs_n)
    );

    always #20 clk = ~clk;

    // ============================================================
    // expected layout of the feeder
    // ============================================================
    function automatic int beats_for(input logic [3:0] c);
        return (c == 4'd3) ? 3 : 4;  // weight address is the short burst
    endfunction

    function automatic int blocks_for(input logic [3:0] c);
        case (c)
            4'd3, 4'd5, 4'd7: return 2;
            4'd4:             return 4;
            4'd6:             return 3;
            default:          return 1;
        endcase
    endfunction

    function automatic int region_start(input logic [3:0] c);
        case (c)
            4'd3:    return 4;
            4'd5:    return 10;
            4'd4:    return 18;
            4'd7:    return 34;
            4'd6:    return 42;
            4'd2:    return 54;
            4'd1:    return 58;
            default: return 0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_val,
                                   input logic [127:0] act_val);
        check_errors++;
        $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp_val,
                 act_val);
    endtask

    // ============================================================
    // bus rules that hold in every cycle
    // ============================================================
    idle_zero: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> data == '0)
        else report_mismatch("data", '0, $sampled(data));

    beat_oe: assert property (@(posedge clk) disable iff (!rst_n) !cs_n |-> !oe_n)
        else report_mismatch("oe_n", '0, 128'($sampled(oe_n)));

    // one cycle of tail after the last beat
    tail_oe: assert property (@(posedge clk) disable iff (!rst_n) $rose(cs_n) |-> !oe_n)
        else report_mismatch("oe_n", '0, 128'($sampled(oe_n)));

    late_oe: assert property (@(posedge clk) disable iff (!rst_n)
                              (!oe_n && cs_n) |-> $past(!cs_n))
        else report_mismatch("oe_n", 128'd1, 128'($sampled(oe_n)));

    // starts at posedge + 2 ns and returns there
    task automatic run_burst(input logic [3:0] c, input logic mode, input logic poke);
        int         len;
        int         cyc;
        int         seen;
        logic       done;
        logic [5:0] word_addr;
        len       = beats_for(c);
        word_addr = 6'(region_start(c) + len * blk_model[c]);
        cyc       = 0;
        seen      = 0;
        done      = 1'b0;
        req       = 1'b1;
        code      = c;
        rd_mode   = mode;
        @(posedge clk);  // accepting edge
        #2;
        req     = 1'b0;
        code    = 4'($urandom);  // must already be captured
        rd_mode = ~mode;
        while (!done && cyc < 20) begin
            @(negedge clk);
            cyc++;
            if (!cs_n) begin
                if (seen == 0) begin
                    assert (cyc == 4)
                        else report_mismatch("cs_n first low cycle", 128'd4, 128'(cyc));
                end
                assert (data == rom_model[word_addr])
                    else report_mismatch("data", rom_model[word_addr], data);
                word_addr++;
                seen++;
            end else if (seen > 0) begin
                done = 1'b1;
            end
            if (poke && cyc == 3) begin  // req while in RD_DATA
                @(posedge clk);
                #2;
                req = 1'b1;
            end
            if (poke && cyc == 4) begin
                @(posedge clk);
                #2;
                req = 1'b0;
            end
        end
        if (seen == 0) begin
            timeout_errors++;
            $display("TIMEOUT at %0t ns: no chip select for code %0d", $time, c);
        end
        assert (seen == len) else report_mismatch("cs_n low cycles", 128'(len), 128'(seen));
        if (mode) begin
            blk_model[c] = (blk_model[c] + 1) % blocks_for(c);
        end
        repeat (3) begin  // no second burst may follow
            @(negedge clk);
            assert (cs_n) else report_mismatch("cs_n", 128'd1, 128'(cs_n));
        end
        @(posedge clk);
        #2;
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        logic [3:0] pick;
        void'($urandom(32'hd9));
        clk            = 1'b0;
        rst_n          = 1'b0;
        req            = 1'b0;
        code           = 4'd0;
        rd_mode        = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        $readmemh("rom_init.hex", rom_model);
        for (int i = 0; i < 16; i++) begin
            blk_model[i] = 0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // quiet bus before any request
        repeat (3) begin
            @(negedge clk);
            assert (cs_n === 1'b1) else report_mismatch("cs_n", 128'd1, 128'(cs_n));
            assert (oe_n === 1'b1) else report_mismatch("oe_n", 128'd1, 128'(oe_n));
            assert (data === '0) else report_mismatch("data", '0, data);
        end
        @(posedge clk);
        #2;

        for (int i = 0; i < 8; i++) begin
            run_burst(4'(i), 1'b0, i == 0);
        end
        run_burst(4'hc, 1'b1, 1'b1);  // unknown code

        // weights wrap after four blocks
        repeat (5) run_burst(4'd4, 1'b1, 1'b0);
        run_burst(4'd4, 1'b0, 1'b0);
        run_burst(4'd4, 1'b1, 1'b0);
        repeat (4) begin
            run_burst(4'd6, 1'b1, 1'b0);
            run_burst(4'd6, 1'b0, 1'b0);
        end
        repeat (3) run_burst(4'd3, 1'b1, 1'b1);

        repeat (16) begin
            pick = 4'($urandom_range(0, 8));
            if (pick == 4'd8) begin
                pick = 4'hb;
            end
            run_burst(pick, 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
        end

        $display("errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
